// ==== filelist.f ====
+incdir+hw
hw/usb_rx_pkg.sv
hw/usb_line_decoder.sv
hw/usb_crc16.sv
hw/usb_packet_receiver.sv
hw/usb_rx_top.sv
dv/usb_rx_checker.sv
dv/usb_rx_asserts.sv
dv/tb_usb_rx.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the USB receive testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_usb_rx \
	-o sim_tb_usb_rx

./obj_dir/sim_tb_usb_rx > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
exit 1

// ==== dv/tb_usb_rx.sv ====
// One line sample per clock at 100 ns; packets are NRZI encoded here and start from J idle
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module tb_usb_rx;

	import usb_rx_pkg::*;

	logic tb_write_enable;
	logic reset;
	logic d_plus;
	logic d_minus;
	usb_byte_t rx_data;
	logic rx_strobe;
	usb_pid_t packet_pid;
	logic packet_done;
	logic rcv_error;

	logic [31:0] lcg_state;
	logic line_level; // d_plus level, d_minus is its inverse
	int ones_run;
	logic bits[$];
	usb_byte_t payload[$];
	int cycle_count;
	int cycle_limit;

	usb_rx_top dut
	(
		.tb_write_enable(tb_write_enable),
		.reset(reset),
		.d_plus(d_plus),
		.d_minus(d_minus),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.packet_pid(packet_pid),
		.packet_done(packet_done),
		.rcv_error(rcv_error)
	);

	usb_rx_checker chk
	(
		.tb_write_enable(tb_write_enable),
		.reset(reset),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.packet_pid(packet_pid),
		.packet_done(packet_done),
		.rcv_error(rcv_error)
	);

	bind usb_rx_top usb_rx_asserts asrt
	(
		.tb_write_enable(tb_write_enable),
		.reset(reset),
		.rx_strobe(rx_strobe),
		.packet_done(packet_done),
		.rcv_error(rcv_error)
	);

	always #50 tb_write_enable = ~tb_write_enable;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function usb_byte_t random_byte();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[23:16];
	endfunction

	// USB CRC16 in reflected form, 0xA001 is 0x8005 bit reversed
	function automatic logic [15:0] crc16_of_payload();
		logic [15:0] crc;
		int i;
		int j;
		crc = 16'hFFFF;
		for (i = 0; i < payload.size(); i++)
			for (j = 0; j < 8; j++)
				if (crc[0] ^ payload[i][j])
					crc = (crc >> 1) ^ 16'hA001;
				else
					crc = crc >> 1;
		return ~crc;
	endfunction

	// Worst case with a stuffed bit every six, plus EOP, idle and drain
	function automatic int packet_cycles(input int nbytes);
		return ((16 + 8 * nbytes) * 7) / 6 + 12;
	endfunction

	task automatic push_byte(input usb_byte_t b);
		int i;
		for (i = 0; i < 8; i++)
			bits.push_back(b[i]); // LSB first on the wire
	endtask

	task automatic drive_pair(input logic dp, input logic dm);
		@(posedge tb_write_enable);
		d_plus <= dp;
		d_minus <= dm;
	endtask

	task automatic drive_bit(input logic b, input logic stuff_zero);
		if (!b)
			line_level = !line_level;
		drive_pair(line_level, !line_level);
		ones_run = b ? ones_run + 1 : 0;
		if (ones_run == `USB_STUFF_LIMIT)
		begin
			ones_run = 0;
			// A one in this slot breaks the stuffing rule
			if (stuff_zero)
				line_level = !line_level; // Stuffed zero
			drive_pair(line_level, !line_level);
		end
	endtask

	task automatic send_packet(input usb_pid_t pid, input logic with_crc,
		input logic stuff_zero, input int flip_bit);
		logic [15:0] crc;
		int i;
		bits.delete();
		push_byte(`USB_SYNC_BYTE);
		push_byte(pid);
		for (i = 0; i < payload.size(); i++)
			push_byte(payload[i]);
		if (with_crc)
		begin
			crc = crc16_of_payload();
			if (flip_bit >= 0)
				crc[flip_bit] = !crc[flip_bit];
			push_byte(crc[7:0]);
			push_byte(crc[15:8]);
		end
		line_level = 1'b1;
		ones_run = 0;
		for (i = 0; i < bits.size(); i++)
			drive_bit(bits[i], stuff_zero);
		drive_pair(1'b0, 1'b0);
		drive_pair(1'b0, 1'b0);
		repeat (5) drive_pair(1'b1, 1'b0);
	endtask

	// Sends one packet and waits for its summary from the DUT
	task automatic run_packet(input usb_pid_t pid, input logic with_crc, input logic stuff_zero,
		input int flip_bit);
		int target;
		target = chk.packets_seen + 1;
		send_packet(pid, with_crc, stuff_zero, flip_bit);
		while (chk.packets_seen < target)
			@(negedge tb_write_enable);
	endtask

	task automatic expect_payload();
		int i;
		for (i = 0; i < payload.size(); i++)
			chk.expect_byte(payload[i]);
	endtask

	always @(posedge tb_write_enable)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: no result after %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		int i;
		tb_write_enable = 1'b0;
		reset = 1'b1;
		d_plus = 1'b1;
		d_minus = 1'b0;
		lcg_state = 32'h573;
		cycle_count = 0;
		cycle_limit = 8 + 3 * packet_cycles(10) + packet_cycles(6) + packet_cycles(4)
			+ 2 * packet_cycles(2) + 200;
		repeat (8) @(posedge tb_write_enable);
		reset <= 1'b0;
		repeat (4) @(posedge tb_write_enable);

		payload.delete();
		for (i = 0; i < 8; i++)
			payload.push_back(random_byte());
		expect_payload();
		chk.expect_packet(`USB_PID_DATA0, 1'b0);
		run_packet(`USB_PID_DATA0, 1'b1, 1'b1, -1);
		chk.report_test("data0 random payload");

		payload = '{8'hFF, 8'hFF, 8'hFF, 8'h00, 8'hFF, 8'h7E, 8'hFF, 8'h3F};
		expect_payload();
		chk.expect_packet(`USB_PID_DATA1, 1'b0);
		run_packet(`USB_PID_DATA1, 1'b1, 1'b1, -1);
		chk.report_test("data1 with stuffed bits");

		payload.delete();
		for (i = 0; i < 8; i++)
			payload.push_back(random_byte());
		expect_payload(); // Bytes still come out, only the summary flags the CRC
		chk.expect_packet(`USB_PID_DATA0, 1'b1);
		run_packet(`USB_PID_DATA0, 1'b1, 1'b1, 5);
		chk.report_test("data0 bad crc");

		payload.delete();
		for (i = 0; i < 4; i++)
			payload.push_back(random_byte());
		chk.expect_packet(8'hC4, 1'b1);
		run_packet(8'hC4, 1'b1, 1'b1, -1);
		chk.report_test("bad pid check nibble");

		payload = '{8'hFF, 8'hFF};
		chk.expect_packet(`USB_PID_DATA0, 1'b1);
		run_packet(`USB_PID_DATA0, 1'b1, 1'b0, -1); // Ones where stuffed zeros belong
		chk.report_test("stuffing violation");

		payload = '{random_byte(), random_byte()};
		chk.expect_packet(`USB_PID_OUT, 1'b0);
		run_packet(`USB_PID_OUT, 1'b0, 1'b1, -1);
		payload = '{random_byte(), random_byte()};
		chk.expect_packet(`USB_PID_IN, 1'b0);
		run_packet(`USB_PID_IN, 1'b0, 1'b1, -1);
		chk.report_test("out then in token");

		repeat (4) @(posedge tb_write_enable);
		chk.report_leftovers();
		$display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
			chk.test_count, chk.check_count, chk.error_count, dut.asrt.fail_count);
		if (chk.error_count == 0 && dut.asrt.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/usb_rx_asserts.sv ====
// Bound into usb_rx_top; fail_count is read by the testbench at the end of the run
`timescale 1ns/1ps

module usb_rx_asserts
(
	input logic tb_write_enable,
	input logic reset,
	input logic rx_strobe,
	input logic packet_done,
	input logic rcv_error
);

	int fail_count = 0;

	strobe_not_with_done: assert property (@(posedge tb_write_enable) disable iff (reset)
		!(rx_strobe && packet_done))
	else
	begin
		$error("rx_strobe and packet_done high in the same cycle");
		fail_count = fail_count + 1;
	end

	// Strobe is cleared by the reset edge
	no_strobe_in_reset: assert property (@(posedge tb_write_enable) reset |=> !rx_strobe)
	else
	begin
		$error("rx_strobe high after a reset cycle");
		fail_count = fail_count + 1;
	end

	error_only_with_done: assert property (@(posedge tb_write_enable) disable iff (reset)
		rcv_error |-> packet_done)
	else
	begin
		$error("rcv_error high without packet_done");
		fail_count = fail_count + 1;
	end

endmodule

// ==== dv/usb_rx_checker.sv ====
// Samples DUT outputs on the rising clock; expected values must be queued before each packet
`timescale 1ns/1ps

module usb_rx_checker
(
	input logic tb_write_enable,
	input logic reset,
	input usb_rx_pkg::usb_byte_t rx_data,
	input logic rx_strobe,
	input usb_rx_pkg::usb_pid_t packet_pid,
	input logic packet_done,
	input logic rcv_error
);

	import usb_rx_pkg::*;

	usb_byte_t exp_bytes[$];
	usb_pid_t exp_pids[$];
	logic exp_errs[$];
	int packets_seen = 0;
	int error_count = 0;
	int test_errors = 0;
	int test_count = 0;
	int check_count = 0;

	task expect_byte(input usb_byte_t b);
		exp_bytes.push_back(b);
	endtask

	task expect_packet(input usb_pid_t pid, input logic err);
		exp_pids.push_back(pid);
		exp_errs.push_back(err);
	endtask

	task note_error();
		error_count = error_count + 1;
		test_errors = test_errors + 1;
	endtask

	task report_test(input string name);
		test_count = test_count + 1;
		$display("Test %0d %s: %s, %0d errors", test_count, name,
			(test_errors == 0) ? "ok" : "failing", test_errors);
		test_errors = 0;
	endtask

	task report_leftovers();
		if (exp_bytes.size() != 0 || exp_pids.size() != 0)
		begin
			$display("Run ended with %0d payload bytes and %0d packets never received",
				exp_bytes.size(), exp_pids.size());
			note_error();
		end
	endtask

	always @(posedge tb_write_enable)
	begin
		usb_byte_t eb;
		usb_pid_t ep;
		logic ee;
		if (!reset)
		begin
			if (rx_strobe)
			begin
				check_count = check_count + 1;
				if (exp_bytes.size() == 0)
				begin
					$display("At %0t rx_strobe came with no payload byte expected", $time);
					note_error();
				end
				else
				begin
					eb = exp_bytes.pop_front();
					if (rx_data !== eb)
					begin
						$display("MISMATCH at %0t rx_data expected %02h actual %02h",
							$time, eb, rx_data);
						note_error();
					end
				end
			end
			if (packet_done)
			begin
				packets_seen = packets_seen + 1;
				check_count = check_count + 1;
				if (exp_pids.size() == 0)
				begin
					$display("At %0t packet_done came with no packet expected", $time);
					note_error();
				end
				else
				begin
					ep = exp_pids.pop_front();
					ee = exp_errs.pop_front();
					if (packet_pid !== ep)
					begin
						$display("MISMATCH at %0t packet_pid expected %02h actual %02h",
							$time, ep, packet_pid);
						note_error();
					end
					if (rcv_error !== ee)
					begin
						$display("MISMATCH at %0t rcv_error expected %0b actual %0b",
							$time, ee, rcv_error);
						note_error();
					end
				end
			end
		end
	end

endmodule

// ==== hw/usb_rx_top.sv ====
// Full-speed receive path with one line sample per clock; every rx_strobe must be taken
`timescale 1ns/1ps

module usb_rx_top
(
	input logic tb_write_enable,
	input logic reset,
	input logic d_plus,
	input logic d_minus,
	output usb_rx_pkg::usb_byte_t rx_data,
	output logic rx_strobe,
	output usb_rx_pkg::usb_pid_t packet_pid,
	output logic packet_done,
	output logic rcv_error
);

	logic bit_valid;
	logic bit_data;
	logic eop;
	logic stuff_error;
	logic crc_clear;
	logic crc_bit_valid;
	logic crc_bit;
	logic crc_ok;

	// Line to decoded bit stream
	usb_line_decoder u_line_decoder
	(
		.tb_write_enable(tb_write_enable),
		.reset(reset),
		.d_plus(d_plus),
		.d_minus(d_minus),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.eop(eop),
		.stuff_error(stuff_error)
	);

	usb_packet_receiver u_packet_receiver
	(
		.tb_write_enable(tb_write_enable),
		.reset(reset),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.eop(eop),
		.stuff_error(stuff_error),
		.crc_ok(crc_ok),
		.crc_clear(crc_clear),
		.crc_bit_valid(crc_bit_valid),
		.crc_bit(crc_bit),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.packet_pid(packet_pid),
		.packet_done(packet_done),
		.rcv_error(rcv_error)
	);

	usb_crc16 u_crc16
	(
		.tb_write_enable(tb_write_enable),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_bit_valid(crc_bit_valid),
		.crc_bit(crc_bit),
		.crc_ok(crc_ok)
	);

endmodule

// ==== hw/usb_packet_receiver.sv ====
// No back-pressure on rx_strobe; the last two bytes of a data packet are taken as CRC
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module usb_packet_receiver
(
	input logic tb_write_enable,
	input logic reset,
	input logic bit_valid,
	input logic bit_data,
	input logic eop,
	input logic stuff_error,
	input logic crc_ok,
	output logic crc_clear,
	output logic crc_bit_valid,
	output logic crc_bit,
	output usb_rx_pkg::usb_byte_t rx_data,
	output logic rx_strobe,
	output usb_rx_pkg::usb_pid_t packet_pid,
	output logic packet_done,
	output logic rcv_error
);

	import usb_rx_pkg::*;

	usb_rx_state_t state;
	logic [2:0] bit_cnt;
	logic [1:0] held_cnt; // Bytes waiting in the holdback
	logic err_q;
	logic is_data_q;
	usb_byte_t shift_q;
	usb_byte_t hold0; // Oldest held byte
	usb_byte_t hold1;
	usb_byte_t byte_in;
	logic byte_done;
	logic pid_ok;
	logic pid_is_data;

	// LSB arrives first, so new bits enter at the top
	assign byte_in = {bit_data, shift_q[7:1]};
	assign byte_done = bit_valid && (bit_cnt == 3'd7);
	assign pid_ok = (byte_in[7:4] == ~byte_in[3:0]);
	assign pid_is_data = (byte_in == `USB_PID_DATA0) || (byte_in == `USB_PID_DATA1);

	always_ff @(posedge tb_write_enable)
	begin
		if (reset)
		begin
			state <= st_idle;
			bit_cnt <= '0;
			held_cnt <= '0;
			err_q <= 1'b0;
			is_data_q <= 1'b0;
			rx_strobe <= 1'b0;
		end
		else
		begin
			rx_strobe <= 1'b0;
			if (bit_valid)
				bit_cnt <= bit_cnt + 3'd1;

			case (state)
				st_idle:
				begin
					if (bit_valid)
					begin
						state <= st_sync;
						err_q <= 1'b0;
						is_data_q <= 1'b0;
						held_cnt <= '0;
					end
				end
				st_sync:
				begin
					if (byte_done)
					begin
						if (byte_in != `USB_SYNC_BYTE)
						begin
							err_q <= 1'b1;
							state <= st_drop;
						end
						else
							state <= st_pid;
					end
				end
				st_pid:
				begin
					if (byte_done)
					begin
						if (!pid_ok)
						begin
							err_q <= 1'b1;
							state <= st_drop;
						end
						else if (pid_is_data)
						begin
							is_data_q <= 1'b1;
							state <= st_payload;
						end
						else
							state <= st_drop; // Token or handshake body is ignored
					end
				end
				st_payload:
				begin
					// Release only once two newer bytes exist
					if (byte_done)
					begin
						if (held_cnt == 2'd2)
							rx_strobe <= 1'b1;
						else
							held_cnt <= held_cnt + 2'd1;
					end
				end
				st_drop:
				begin
					// Wait for end of packet
				end
				st_eop:
				begin
					state <= st_idle;
					bit_cnt <= '0;
				end
				default:
					state <= st_idle;
			endcase

			if (state != st_idle && state != st_eop)
			begin
				if (stuff_error)
				begin
					err_q <= 1'b1;
					state <= st_drop; // No more payload after a stuffing fault
				end
				if (eop)
				begin
					state <= st_eop;
					// Truncated before the PID, or cut mid-byte
					if (bit_cnt != 3'd0 || state == st_sync || state == st_pid)
						err_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge tb_write_enable)
	begin
		if (bit_valid)
			shift_q <= byte_in;
		if (byte_done && state == st_pid)
			packet_pid <= byte_in;
		if (byte_done && state == st_payload)
		begin
			hold1 <= byte_in;
			hold0 <= hold1;
			rx_data <= hold0; // Paired with rx_strobe when two bytes were held
		end
	end

	// CRC runs over payload only and stays preset between packets
	assign crc_clear = (state == st_idle);
	assign crc_bit_valid = bit_valid && (state == st_payload);
	assign crc_bit = bit_data;

	assign packet_done = (state == st_eop);
	assign rcv_error = packet_done && (err_q || (is_data_q && !crc_ok));

endmodule

// ==== hw/usb_crc16.sv ====
// Serial CRC16 fed in line order; crc_ok is only meaningful after the CRC bytes went in
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module usb_crc16
(
	input logic tb_write_enable,
	input logic reset,
	input logic crc_clear,
	input logic crc_bit_valid,
	input logic crc_bit,
	output logic crc_ok
);

	import usb_rx_pkg::*;

	localparam usb_crc16_t crc_poly = 16'h8005;

	usb_crc16_t crc_q;
	logic feedback;

	assign feedback = crc_q[15] ^ crc_bit;

	always_ff @(posedge tb_write_enable)
	begin
		if (reset)
			crc_q <= '1;
		else if (crc_clear)
			crc_q <= '1; // Preset for the next packet
		else if (crc_bit_valid)
		begin
			if (feedback)
				crc_q <= {crc_q[14:0], 1'b0} ^ crc_poly;
			else
				crc_q <= {crc_q[14:0], 1'b0};
		end
	end

	// Data and transmitted CRC together leave a fixed remainder
	assign crc_ok = (crc_q == `USB_CRC16_RESIDUE);

endmodule

// ==== hw/usb_line_decoder.sv ====
// One line sample per clock, no clock recovery; idle is J and a packet starts at the first K
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module usb_line_decoder
(
	input logic tb_write_enable,
	input logic reset,
	input logic d_plus,
	input logic d_minus,
	output logic bit_valid,
	output logic bit_data,
	output logic eop,
	output logic stuff_error
);

	logic dp_q; // Sampled pair
	logic dm_q;
	logic prev_dp; // Last J/K level, SE0 excluded
	logic se0_prev;
	logic active; // Inside a packet
	logic [2:0] ones_cnt;
	logic se0_now;
	logic nrzi_bit;

	assign se0_now = !dp_q && !dm_q;
	assign nrzi_bit = (dp_q == prev_dp); // No transition is a one

	always_ff @(posedge tb_write_enable)
	begin
		if (reset)
		begin
			dp_q <= 1'b1; // Line parks at J
			dm_q <= 1'b0;
			prev_dp <= 1'b1;
			se0_prev <= 1'b0;
			active <= 1'b0;
			ones_cnt <= '0;
			bit_valid <= 1'b0;
			eop <= 1'b0;
			stuff_error <= 1'b0;
		end
		else
		begin
			dp_q <= d_plus;
			dm_q <= d_minus;
			se0_prev <= se0_now;
			bit_valid <= 1'b0;
			eop <= 1'b0;
			stuff_error <= 1'b0;

			if (se0_now)
			begin
				// Second SE0 in a row ends the packet
				if (se0_prev && active)
				begin
					eop <= 1'b1;
					active <= 1'b0;
					ones_cnt <= '0;
				end
			end
			else
			begin
				prev_dp <= dp_q;
				if (!active)
				begin
					// J to K is the first SYNC zero
					if (!dp_q)
					begin
						active <= 1'b1;
						bit_valid <= 1'b1;
						bit_data <= 1'b0;
						ones_cnt <= '0;
					end
				end
				else if (ones_cnt == `USB_STUFF_LIMIT)
				begin
					// Stuffed bit is dropped, it must be a zero
					ones_cnt <= '0;
					if (nrzi_bit)
						stuff_error <= 1'b1;
				end
				else
				begin
					bit_valid <= 1'b1;
					bit_data <= nrzi_bit;
					ones_cnt <= nrzi_bit ? ones_cnt + 3'd1 : 3'd0;
				end
			end
		end
	end

endmodule

// ==== hw/usb_rx_pkg.sv ====
// Types shared by the receiver blocks; widths are fixed by the USB protocol
package usb_rx_pkg;

	// One byte off the wire
	typedef logic [7:0] usb_byte_t;

	// PID with its check nibble in the upper half
	typedef logic [7:0] usb_pid_t;

	typedef logic [15:0] usb_crc16_t;

	// Receiver FSM
	typedef enum logic [2:0]
	{
		st_idle, // Waiting for the first K
		st_sync, // Collecting the SYNC byte
		st_pid, // Collecting the PID byte
		st_payload, // Data bytes and CRC
		st_drop, // Tokens, handshakes and broken packets
		st_eop // Packet summary cycle
	} usb_rx_state_t;

endpackage

// ==== hw/usb_rx_macros.svh ====
// PID values are whole bytes as received LSB-first; CRC residue is for an MSB-first shift register
`ifndef USB_RX_MACROS_SVH
`define USB_RX_MACROS_SVH

// Token PIDs
`define USB_PID_OUT 8'hE1
`define USB_PID_IN 8'h69

// Data PIDs, the only ones followed by payload and CRC16
`define USB_PID_DATA0 8'hC3
`define USB_PID_DATA1 8'h4B

// Handshakes
`define USB_PID_ACK 8'hD2
`define USB_PID_NAK 8'h5A

// KJKJKJKK on the line, seven zeros then a one
`define USB_SYNC_BYTE 8'h80

// Left in the register after data plus complemented CRC
`define USB_CRC16_RESIDUE 16'h800D

`define USB_STUFF_LIMIT 3'd6 // Ones before a forced zero

`endif
